//--- logic/bdDecoderPkg.sv
`default_nettype none

package bdDecoderPkg;

  ////////////////////
  // widths
  ////////////////////

  // raw word out of the funnel, route prefix then payload
  localparam int RawWidth = 34;
  // widest payload after AM halves are joined
  localparam int PayloadWidth = 38;
  // widest payload carried in one raw word
  localparam int SinglePayloadWidth = 32;
  // one half of a DUMP_AM word
  localparam int AmHalfWidth = 19;
  // leaves in the route table
  localparam int NumLeaves = 13;

  ////////////////////
  // leaf codes
  ////////////////////

  // value doubles as the index into the route tables
  typedef enum logic [3:0] {
    DUMP_AM,
    DUMP_MM,
    DUMP_PAT,
    DUMP_POST_FIFO0,
    DUMP_POST_FIFO1,
    DUMP_PRE_FIFO,
    DUMP_TAT0,
    DUMP_TAT1,
    NRNI,
    OVFLW0,
    OVFLW1,
    RO_ACC,
    RO_TAT,
    INVALID
  } leafT;

  typedef logic [RawWidth-1:0] rawWordT;

  typedef struct packed {
    leafT                    leaf;
    logic [PayloadWidth-1:0] payload;
  } decodedWordT;

  ////////////////////
  // route tables
  ////////////////////

  // routes left aligned in the raw word
  // both overflow leaves only have the known 14 bit prefix
  localparam rawWordT routeTable [NumLeaves] = '{
    {15'b100100000000000, 19'b0},
    {15'b100100000000001, 19'b0},
    {14'b10010000000001, 20'b0},
    {15'b100100000001100, 19'b0},
    {15'b100100000001101, 19'b0},
    {14'b10010000000101, 20'b0},
    {5'b10000, 29'b0},
    {5'b10001, 29'b0},
    {3'b101, 31'b0},
    {14'b10010000000100, 20'b0},
    {14'b10010000000100, 20'b0},
    {2'b01, 32'b0},
    {2'b00, 32'b0}
  };

  // ones over the route bits of each leaf
  localparam rawWordT routeMaskTable [NumLeaves] = '{
    {{15{1'b1}}, 19'b0},
    {{15{1'b1}}, 19'b0},
    {{14{1'b1}}, 20'b0},
    {{15{1'b1}}, 19'b0},
    {{15{1'b1}}, 19'b0},
    {{14{1'b1}}, 20'b0},
    {{5{1'b1}}, 29'b0},
    {{5{1'b1}}, 29'b0},
    {{3{1'b1}}, 31'b0},
    {{14{1'b1}}, 20'b0},
    {{14{1'b1}}, 20'b0},
    {{2{1'b1}}, 32'b0},
    {{2{1'b1}}, 32'b0}
  };

endpackage

`default_nettype wire

//--- logic/wordFifo.sv
`timescale 1ns/1ps
`default_nettype none

module wordFifo #(
  parameter type PayloadT = logic,
  parameter int  Depth    = 4
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    inValid,
  output logic    inReady,
  input  PayloadT inData,
  output logic    outValid,
  input  logic    outReady,
  output PayloadT outData
);

  // pointer must be at least one bit wide for a single entry
  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  ////////////////////
  // storage
  ////////////////////

  PayloadT mem [Depth];

  logic [PtrWidth-1:0] wrPtr;
  logic [PtrWidth-1:0] rdPtr;
  logic [CntWidth-1:0] count;

  logic doWrite;
  logic doRead;

  // handshakes on both sides
  assign doWrite = inValid && inReady;
  assign doRead  = outValid && outReady;

  // flags straight off the registered count
  assign inReady  = (count != CntWidth'(Depth));
  assign outValid = (count != '0);
  assign outData  = mem[rdPtr];

  ////////////////////
  // control
  ////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      // wrap by compare, depth need not be a power of two
      if (doWrite) begin
        wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + PtrWidth'(1);
      end
      if (doRead) begin
        rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + PtrWidth'(1);
      end
      // count moves only when one side is idle
      if (doWrite && !doRead) begin
        count <= count + CntWidth'(1);
      end else if (doRead && !doWrite) begin
        count <= count - CntWidth'(1);
      end
    end
  end

  // data array
  always_ff @(posedge clk) begin
    if (doWrite) begin
      mem[wrPtr] <= inData;
    end
  end

endmodule

`default_nettype wire

//--- logic/bdRouteDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module bdRouteDecoder
  import bdDecoderPkg::*;
(
  input  logic        clk,
  input  logic        arstN,
  input  logic        inValid,
  output logic        inReady,
  input  rawWordT     inWord,
  output logic        outValid,
  input  logic        outReady,
  output decodedWordT outWord
);

  localparam int CountWidth = $clog2(NumLeaves + 1);

  // both overflow leaves share one prefix, so they always hit together
  localparam logic [NumLeaves-1:0] OvflwPattern =
    (NumLeaves'(1) << OVFLW0) | (NumLeaves'(1) << OVFLW1);

  ////////////////////
  // route match
  ////////////////////

  logic [NumLeaves-1:0]  routeHit;
  logic [CountWidth-1:0] hitCount;
  leafT                  hitLeaf;
  rawWordT               hitMask;

  // every leaf checked at once
  always_comb begin
    for (int i = 0; i < NumLeaves; i++) begin
      routeHit[i] = ((inWord & routeMaskTable[i]) == routeTable[i]);
    end
  end

  // count hits, last hit leaf, and OR of hit masks
  always_comb begin
    hitCount = '0;
    hitLeaf  = INVALID;
    hitMask  = '0;
    for (int i = 0; i < NumLeaves; i++) begin
      if (routeHit[i]) begin
        hitCount = hitCount + CountWidth'(1);
        hitLeaf  = leafT'(i);
        hitMask  = hitMask | routeMaskTable[i];
      end
    end
  end

  ////////////////////
  // leaf and payload
  ////////////////////

  leafT                    decLeaf;
  rawWordT                 decMask;
  rawWordT                 maskedWord;
  logic [PayloadWidth-1:0] decPayload;

  // one-hot to code
  always_comb begin
    if (hitCount == CountWidth'(1)) begin
      decLeaf = hitLeaf;
    end else if (routeHit == OvflwPattern) begin
      // overflow class reports as class 0
      decLeaf = OVFLW0;
    end else begin
      decLeaf = INVALID;
    end
  end

  // invalid words keep every bit, the low 32 pass on
  assign decMask    = (decLeaf == INVALID) ? '0 : hitMask;
  assign maskedWord = inWord & ~decMask;
  assign decPayload = PayloadWidth'(maskedWord[SinglePayloadWidth-1:0]);

  ////////////////////
  // output register
  ////////////////////

  // take a new word whenever the held one leaves
  assign inReady = !outValid || outReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inReady && inValid) begin
      outWord.leaf    <= decLeaf;
      outWord.payload <= decPayload;
    end
  end

endmodule

`default_nettype wire

//--- logic/amDeserializer.sv
`timescale 1ns/1ps
`default_nettype none

module amDeserializer
  import bdDecoderPkg::*;
(
  input  logic        clk,
  input  logic        arstN,
  input  logic        inValid,
  output logic        inReady,
  input  decodedWordT inWord,
  output logic        outValid,
  input  logic        outReady,
  output decodedWordT outWord
);

  ////////////////////
  // half tracking
  ////////////////////

  // set while a first AM half waits for its partner
  logic pendingFlag;
  // first half, becomes the low bits of the joined word
  logic [AmHalfWidth-1:0] heldHalf;

  logic inAccept;
  logic isAm;
  logic isFirstHalf;
  logic isSecondHalf;
  logic emitWord;

  // one output register for every leaf keeps arrival order
  assign inReady  = !outValid || outReady;
  assign inAccept = inValid && inReady;

  assign isAm         = (inWord.leaf == DUMP_AM);
  assign isFirstHalf  = isAm && !pendingFlag;
  assign isSecondHalf = isAm && pendingFlag;

  // first half is swallowed
  assign emitWord = !isFirstHalf;

  ////////////////////
  // joined word
  ////////////////////

  logic [PayloadWidth-1:0] joinedPayload;

  // second half on top of the held first half
  assign joinedPayload = {inWord.payload[AmHalfWidth-1:0], heldHalf};

  ////////////////////
  // control
  ////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid    <= 1'b0;
      pendingFlag <= 1'b0;
    end else begin
      if (inReady) begin
        // an empty slot or a leaving word frees the register
        outValid <= inValid && emitWord;
      end
      if (inAccept && isAm) begin
        // toggles between first and second half
        pendingFlag <= !pendingFlag;
      end
    end
  end

  ////////////////////
  // payload
  ////////////////////

  always_ff @(posedge clk) begin
    if (inAccept && isFirstHalf) begin
      heldHalf <= inWord.payload[AmHalfWidth-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (inAccept && emitWord) begin
      if (isSecondHalf) begin
        outWord.leaf    <= DUMP_AM;
        outWord.payload <= joinedPayload;
      end else begin
        // any other leaf as decoded
        outWord <= inWord;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/bdDecoderTop.sv
`timescale 1ns/1ps
`default_nettype none

module bdDecoderTop
  import bdDecoderPkg::*;
#(
  parameter int InFifoDepth  = 4,
  parameter int OutFifoDepth = 4
) (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    inValid,
  output logic                    inReady,
  input  rawWordT                 inWord,
  output logic                    outValid,
  input  logic                    outReady,
  output leafT                    outLeaf,
  output logic [PayloadWidth-1:0] outPayload
);

  ////////////////////
  // links
  ////////////////////

  // input FIFO to route decoder
  logic    rawValid;
  logic    rawReady;
  rawWordT rawWord;

  // route decoder to deserializer
  logic        decValid;
  logic        decReady;
  decodedWordT decWord;

  // deserializer to output FIFO
  logic        desValid;
  logic        desReady;
  decodedWordT desWord;

  decodedWordT outWord;

  ////////////////////
  // chain
  ////////////////////

  wordFifo #(.PayloadT(rawWordT), .Depth(InFifoDepth)) inFifo_i (
    .clk, .arstN,
    .inValid (inValid), .inReady (inReady), .inData  (inWord),
    .outValid(rawValid), .outReady(rawReady), .outData(rawWord)
  );

  bdRouteDecoder routeDecoder_i (
    .clk, .arstN,
    .inValid (rawValid), .inReady (rawReady), .inWord (rawWord),
    .outValid(decValid), .outReady(decReady), .outWord(decWord)
  );

  amDeserializer amDeserializer_i (
    .clk, .arstN,
    .inValid (decValid), .inReady (decReady), .inWord (decWord),
    .outValid(desValid), .outReady(desReady), .outWord(desWord)
  );

  wordFifo #(.PayloadT(decodedWordT), .Depth(OutFifoDepth)) outFifo_i (
    .clk, .arstN,
    .inValid (desValid), .inReady (desReady), .inData  (desWord),
    .outValid(outValid), .outReady(outReady), .outData(outWord)
  );

  // split the output struct
  assign outLeaf    = outWord.leaf;
  assign outPayload = outWord.payload;

endmodule

`default_nettype wire

//--- tb/bdDecoder_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module bdDecoder_asserts
  import bdDecoderPkg::*;
(
  input logic                    clk,
  input logic                    arstN,
  input logic                    inValid,
  input logic                    inReady,
  input rawWordT                 inWord,
  input logic                    outValid,
  input logic                    outReady,
  input leafT                    outLeaf,
  input logic [PayloadWidth-1:0] outPayload
);

  // one counter per property, summed for the testbench
  int resetFails   = 0;
  int holdOutFails = 0;
  int holdInFails  = 0;
  int unknownFails = 0;
  int failCount;

  assign failCount = resetFails + holdOutFails + holdInFails + unknownFails;

  // output FIFO empty while in reset
  resetQuiet: assert property (@(posedge clk) !arstN |-> !outValid)
    else begin
      resetFails++;
      $error("outValid high while arstN is low");
    end

  // stalled output word holds
  outHold: assert property (@(posedge clk) disable iff (!arstN)
    outValid && !outReady |=> outValid && $stable(outLeaf) && $stable(outPayload))
    else begin
      holdOutFails++;
      $error("output word changed or dropped while outReady was low");
    end

  // driver side of the input handshake
  inHold: assert property (@(posedge clk) disable iff (!arstN)
    inValid && !inReady |=> inValid && $stable(inWord))
    else begin
      holdInFails++;
      $error("input word changed or dropped before inReady");
    end

  outKnown: assert property (@(posedge clk) disable iff (!arstN)
    outValid |-> !$isunknown({outLeaf, outPayload}))
    else begin
      unknownFails++;
      $error("X on outLeaf or outPayload while outValid is high");
    end

endmodule

bind bdDecoderTop bdDecoder_asserts asserts_i (
  .clk       (clk),
  .arstN     (arstN),
  .inValid   (inValid),
  .inReady   (inReady),
  .inWord    (inWord),
  .outValid  (outValid),
  .outReady  (outReady),
  .outLeaf   (outLeaf),
  .outPayload(outPayload)
);

`default_nettype wire

//--- tb/bdDecoderTbTasks.svh
`ifndef BD_DECODER_TB_TASKS_SVH
`define BD_DECODER_TB_TASKS_SVH
`default_nettype none

////////////////////
// word building
////////////////////

// 34 random bits from two draws
function automatic rawWordT randomRaw();
  rawWordT r;
  r[31:0] = $random(seed);
  r[RawWidth-1:32] = 2'($random(seed));
  return r;
endfunction

// table route over random payload bits
function automatic rawWordT buildWord(input int leafIdx);
  return (randomRaw() & ~routeMaskTable[leafIdx]) | routeTable[leafIdx];
endfunction

// no route starts with 11
function automatic rawWordT buildInvalid();
  rawWordT r;
  r = randomRaw();
  r[RawWidth-1 -: 2] = 2'b11;
  return r;
endfunction

////////////////////
// reference model
////////////////////

function automatic void modelWord(input rawWordT w);
  int hits;
  int ovflHits;
  int lastHit;
  rawWordT cleared;
  decodedWordT exp;
  hits = 0;
  ovflHits = 0;
  lastHit = 0;
  for (int i = 0; i < NumLeaves; i++) begin
    if ((w & routeMaskTable[i]) == routeTable[i]) begin
      hits++;
      lastHit = i;
      if (i == int'(OVFLW0) || i == int'(OVFLW1)) begin
        ovflHits++;
      end
    end
  end
  // exactly one leaf, or the shared overflow prefix
  if (hits == 1) begin
    exp.leaf = leafT'(lastHit);
  end else if (hits == 2 && ovflHits == 2) begin
    exp.leaf = OVFLW0;
  end else begin
    exp.leaf = INVALID;
  end
  cleared = (exp.leaf == INVALID) ? w : (w & ~routeMaskTable[exp.leaf]);
  exp.payload = PayloadWidth'(cleared[SinglePayloadWidth-1:0]);
  // AM word is expected only once its second half is in
  if (exp.leaf != DUMP_AM) begin
    expQ.push_back(exp);
  end else if (!amPending) begin
    amHalf = exp.payload[AmHalfWidth-1:0];
    amPending = 1'b1;
  end else begin
    exp.payload = {exp.payload[AmHalfWidth-1:0], amHalf};
    amPending = 1'b0;
    expQ.push_back(exp);
  end
endfunction

////////////////////
// handshakes
////////////////////

// called on a falling edge, holds the word until taken
task automatic sendWord(input rawWordT w);
  int waitCycles;
  waitCycles = 0;
  // stimulus stops after the first stuck handshake
  if (timeoutErrors == 0) begin
    inValid = 1'b1;
    inWord = w;
    while (!inReady && waitCycles < TimeoutCycles) begin
      @(negedge clk);
      waitCycles++;
    end
    if (!inReady) begin
      $display("timeout at %0t: input FIFO never accepted the word", $time);
      timeoutErrors++;
    end else begin
      // taken on the next rising edge
      modelWord(w);
      @(negedge clk);
      inValid = 1'b0;
    end
  end
endtask

task automatic drainOutput();
  int waitCycles;
  waitCycles = 0;
  while (expQ.size() != 0 && waitCycles < TimeoutCycles) begin
    @(negedge clk);
    waitCycles++;
  end
  if (expQ.size() != 0) begin
    $display("timeout at %0t: %0d expected words never came out", $time, expQ.size());
    leftoverWords += expQ.size();
    expQ.delete();
  end
endtask

`default_nettype wire
`endif

//--- tb/bdDecoderTb.sv
`timescale 1ns/1ps
`default_nettype none

module bdDecoderTb
  import bdDecoderPkg::*;
();

  localparam int TimeoutCycles = 1000;
  localparam int StreamWords   = 300;

  logic                    clk = 1'b0;
  logic                    arstN;
  logic                    inValid;
  logic                    inReady;
  rawWordT                 inWord;
  logic                    outValid;
  logic                    outReady = 1'b0;
  leafT                    outLeaf;
  logic [PayloadWidth-1:0] outPayload;

  // stimulus and output stalls draw from separate streams
  int seed      = 32'h5157ad46;
  int readySeed = 32'h5157ad47;

  logic stallOut   = 1'b0;
  logic sawInStall = 1'b0;

  // model state
  decodedWordT            expQ[$];
  logic                   amPending = 1'b0;
  logic [AmHalfWidth-1:0] amHalf;

  int mismatchErrors = 0;
  int checkErrors    = 0;
  int timeoutErrors  = 0;
  int leftoverWords  = 0;

  always #4 clk = ~clk;

  bdDecoderTop dut_i (
    .clk, .arstN,
    .inValid, .inReady, .inWord,
    .outValid, .outReady, .outLeaf, .outPayload
  );

  `include "bdDecoderTbTasks.svh"

  task automatic finishRun();
    int assertFails;
    assertFails = dut_i.asserts_i.failCount;
    $display("mismatches %0d, check errors %0d, timeouts %0d, leftover %0d, assertions %0d",
             mismatchErrors, checkErrors, timeoutErrors, leftoverWords, assertFails);
    if (mismatchErrors + checkErrors + timeoutErrors + leftoverWords + assertFails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  ////////////////////
  // scoreboard
  ////////////////////

  // ready set here holds through the next rising edge
  always @(negedge clk) begin
    decodedWordT exp;
    if (arstN) begin
      outReady = stallOut ? 1'($random(readySeed)) : 1'b1;
      if (outValid && outReady && expQ.size() == 0) begin
        $display("unexpected output word at %0t, leaf %s", $time, outLeaf.name());
        mismatchErrors++;
      end else if (outValid && outReady) begin
        exp = expQ.pop_front();
        if (outLeaf !== exp.leaf) begin
          $display("mismatch at %0t: outLeaf expected %s got %s",
                   $time, exp.leaf.name(), outLeaf.name());
          mismatchErrors++;
        end
        if (outPayload !== exp.payload) begin
          $display("mismatch at %0t: outPayload expected %h got %h",
                   $time, exp.payload, outPayload);
          mismatchErrors++;
        end
      end
    end
  end

  // proof that the stall reached the input FIFO
  always @(posedge clk) begin
    if (inValid && !inReady) begin
      sawInStall <= 1'b1;
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    rawWordT w;
    int pick;
    arstN = 1'b0;
    inValid = 1'b0;
    inWord = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;

    // idle after reset
    repeat (2) @(negedge clk);
    if (outValid !== 1'b0) begin
      $display("mismatch at %0t: outValid expected 0 got %b", $time, outValid);
      checkErrors++;
    end
    if (inReady !== 1'b1) begin
      $display("mismatch at %0t: inReady expected 1 got %b", $time, inReady);
      checkErrors++;
    end

    // every table route, AM as a full pair
    for (int i = 0; i < NumLeaves; i++) begin
      sendWord(buildWord(i));
      if (i == int'(DUMP_AM)) begin
        sendWord(buildWord(i));
      end
    end

    // overflow prefix with bit 15 low and high
    w = buildWord(int'(OVFLW0));
    w[RawWidth-15] = 1'b0;
    sendWord(w);
    w[RawWidth-15] = 1'b1;
    sendWord(w);

    sendWord(buildInvalid());

    // AM halves around two other leaves
    sendWord(buildWord(int'(DUMP_AM)));
    sendWord(buildWord(int'(NRNI)));
    sendWord(buildWord(int'(RO_ACC)));
    sendWord(buildWord(int'(DUMP_AM)));
    drainOutput();

    // random stream, output ready low about half the time
    stallOut = 1'b1;
    repeat (StreamWords) begin
      pick = $unsigned($random(seed)) % (NumLeaves + 1);
      sendWord(pick == NumLeaves ? buildInvalid() : buildWord(pick));
    end
    stallOut = 1'b0;
    drainOutput();
    if (!sawInStall) begin
      $display("output stalls never backed up into the input FIFO");
      checkErrors++;
    end
    finishRun();
  end

endmodule

`default_nettype wire

//--- bdDecoder.f
+incdir+tb
logic/bdDecoderPkg.sv
logic/wordFifo.sv
logic/bdRouteDecoder.sv
logic/amDeserializer.sv
logic/bdDecoderTop.sv
tb/bdDecoder_asserts.sv
tb/bdDecoderTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module bdDecoderTb -f bdDecoder.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running past assertion errors so the testbench prints its summary
simOut=$(./obj_dir/VbdDecoderTb +verilator+error+limit+1000)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1
